//--- verilog/branchPkg.sv
`default_nettype none

package branchPkg;

  // branch class of the instruction held in decode
  // OTHER sits at zero so a cleared record is all zeros
  typedef enum logic [2:0] {
    OTHER = 3'd0,
    BRU   = 3'd1,
    BCC   = 3'd2,
    IMM   = 3'd3,
    RTD   = 3'd4
  } opClass;

  // condition field from rd bits 2 to 0
  typedef enum logic [2:0] {
    EQ = 3'd0,
    NE = 3'd1,
    LT = 3'd2,
    LE = 3'd3,
    GT = 3'd4,
    GE = 3'd5
  } condCode;

  // operand forwarding source
  typedef enum logic [1:0] {
    REGA     = 2'd0,
    RESULT   = 2'd1,
    LOADDATA = 2'd2
  } fwdSel;

  // latched decode state of 7 bits
  typedef struct packed {
    opClass  cls;
    condCode cond;
    logic    delay;
  } decodeRec;

  // word address made of byte address bits 31 to 2
  typedef logic [29:0] pcWord;

  // three candidate operands of 32 bits each
  typedef struct packed {
    logic [31:0] regA;
    logic [31:0] result;
    logic [31:0] loadData;
  } operandIn;

  // major opcodes
  localparam logic [5:0] OPC_BRU_A = 6'o46;
  localparam logic [5:0] OPC_BRU_B = 6'o56;
  localparam logic [5:0] OPC_BCC_A = 6'o47;
  localparam logic [5:0] OPC_BCC_B = 6'o57;
  localparam logic [5:0] OPC_IMM   = 6'o54;
  localparam logic [5:0] OPC_RTD   = 6'o55;

endpackage

`default_nettype wire

//--- verilog/instDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instDecode (
  input  logic                gclk,
  input  logic                grst,
  input  logic                dEn,
  input  logic [31:0]         instWord,
  input  logic                fSkip,
  output branchPkg::decodeRec rec
);
  import branchPkg::*;

  logic [5:0] opc;
  logic [4:0] rd;
  logic [4:0] ra;
  opClass     cls;
  decodeRec   nextRec;

  // instruction fields with the opcode in the top six bits
  assign opc = instWord[31:26];
  assign rd  = instWord[25:21];
  assign ra  = instWord[20:16];

  // opcode to branch class
  always_comb begin
    case (opc)
      OPC_BRU_A, OPC_BRU_B: cls = BRU;
      OPC_BCC_A, OPC_BCC_B: cls = BCC;
      OPC_IMM:              cls = IMM;
      OPC_RTD:              cls = RTD;
      default:              cls = OTHER;
    endcase
  end

  // assemble the record to be latched
  always_comb begin
    nextRec.cls   = cls;
    // condition only matters for BCC
    nextRec.cond  = condCode'(rd[2:0]);
    nextRec.delay = 1'b0;
    case (cls)
      // unconditional delay slot flag lives in ra
      BRU:     nextRec.delay = ra[4];
      // conditional delay slot flag lives in rd
      BCC:     nextRec.delay = rd[4];
      default: nextRec.delay = 1'b0;
    endcase
  end

  // record register
  // squash beats the decode enable
  always_ff @(posedge gclk) begin
    if (grst || fSkip) begin
      rec <= '{cls: OTHER, cond: EQ, delay: 1'b0};
    end else if (dEn) begin
      rec <= nextRec;
    end
  end

endmodule

`default_nettype wire

//--- verilog/branchResolve.sv
`timescale 1ns/100ps
`default_nettype none

module branchResolve (
  input  branchPkg::decodeRec rec,
  input  branchPkg::fwdSel    mxAlt,
  input  branchPkg::operandIn operands,
  output logic                taken,
  output logic                dSkip,
  output logic                fSkip
);
  import branchPkg::*;

  logic [31:0] opVal;
  logic        isZero;
  logic        isNeg;
  logic        baseTrue;
  logic        invertAnswer;
  logic        condValid;
  logic        condHolds;
  logic        squash;

  // forwarding mux
  // alu result and load data bypass the register file
  always_comb begin
    case (mxAlt)
      RESULT:   opVal = operands.result;
      LOADDATA: opVal = operands.loadData;
      default:  opVal = operands.regA;
    endcase
  end

  // signed flags of the selected operand
  assign isZero = (opVal == 32'd0);
  assign isNeg  = opVal[31];

  // each condition is a base test that may be inverted
  // NE = !EQ, GE = !LT, GT = !LE
  always_comb begin
    baseTrue     = 1'b0;
    invertAnswer = 1'b0;
    condValid    = 1'b1;
    case (rec.cond)
      EQ: begin
        baseTrue = isZero;
      end
      NE: begin
        baseTrue     = isZero;
        invertAnswer = 1'b1;
      end
      LT: begin
        baseTrue = isNeg;
      end
      LE: begin
        baseTrue = isNeg | isZero;
      end
      GT: begin
        // implemented as an inverted le
        baseTrue     = isNeg | isZero;
        invertAnswer = 1'b1;
      end
      GE: begin
        baseTrue     = isNeg;
        invertAnswer = 1'b1;
      end
      default: begin
        // codes 6 and 7 never branch
        condValid = 1'b0;
      end
    endcase
  end

  assign condHolds = condValid & (baseTrue ^ invertAnswer);

  // bru always goes and bcc only when the condition holds
  assign taken = (rec.cls == BRU) | ((rec.cls == BCC) & condHolds);

  // without a delay slot the instruction behind the branch is killed
  assign squash = taken & ~rec.delay;

  // same squash seen from decode and from fetch
  assign dSkip = squash;
  assign fSkip = squash;

endmodule

`default_nettype wire

//--- verilog/pcPipeline.sv
`timescale 1ns/100ps
`default_nettype none

module pcPipeline (
  input  logic                gclk,
  input  logic                grst,
  input  logic                xEn,
  input  branchPkg::decodeRec rec,
  input  logic                taken,
  input  logic                dSkip,
  input  branchPkg::pcWord    target,
  input  logic                fetchAdvance,
  output logic [31:0]         fetchAddr,
  output branchPkg::pcWord    pc,
  output branchPkg::pcWord    linkPc,
  output logic                xSkip,
  output logic [1:0]          atom
);
  import branchPkg::*;

  pcWord nextFetch;
  pcWord preFetch;
  pcWord fetchPc;
  logic  safe;

  // next fetch word
  // a taken branch overrides sequential stepping
  always_comb begin
    if (taken) begin
      nextFetch = target;
    end else begin
      nextFetch = preFetch + pcWord'(fetchAdvance);
    end
  end

  // byte address to the instruction side
  assign fetchAddr = {nextFetch, 2'b00};

  // instruction boundary is safe only for non-branch, non-imm
  assign safe = (rec.cls == OTHER);

  // pc chain, skip flag and atomic tracker
  // all step together on the execute enable
  always_ff @(posedge gclk) begin
    if (grst) begin
      preFetch <= '0;
      fetchPc  <= '0;
      pc       <= '0;
      linkPc   <= '0;
      xSkip    <= 1'b0;
      atom     <= 2'b00;
    end else if (xEn) begin
      preFetch <= nextFetch;
      fetchPc  <= preFetch;
      pc       <= fetchPc;
      // link address for branch-and-link
      linkPc   <= pc;
      xSkip    <= dSkip;
      // shift bit 0 up, toggle it on a safe boundary
      atom     <= {atom[0], atom[0] ^ safe};
    end
  end

endmodule

`default_nettype wire

//--- verilog/branchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
  input  logic                gclk,
  input  logic                grst,
  input  logic                dEn,
  input  logic                xEn,
  input  logic [31:0]         instWord,
  input  branchPkg::fwdSel    mxAlt,
  input  branchPkg::operandIn operands,
  input  logic                fetchAdvance,
  output logic [31:0]         fetchAddr,
  output branchPkg::pcWord    pc,
  output branchPkg::pcWord    linkPc,
  output logic                dSkip,
  output logic                xSkip,
  output logic [1:0]          atom
);
  import branchPkg::*;

  decodeRec rec;
  logic     taken;
  logic     fSkip;

  // decode record that the fetch squash clears
  instDecode u_instDecode (
    .gclk     (gclk),
    .grst     (grst),
    .dEn      (dEn),
    .instWord (instWord),
    .fSkip    (fSkip),
    .rec      (rec)
  );

  // branch decision
  branchResolve u_branchResolve (
    .rec      (rec),
    .mxAlt    (mxAlt),
    .operands (operands),
    .taken    (taken),
    .dSkip    (dSkip),
    .fSkip    (fSkip)
  );

  // target is the word-aligned alu result
  pcPipeline u_pcPipeline (
    .gclk         (gclk),
    .grst         (grst),
    .xEn          (xEn),
    .rec          (rec),
    .taken        (taken),
    .dSkip        (dSkip),
    .target       (operands.result[31:2]),
    .fetchAdvance (fetchAdvance),
    .fetchAddr    (fetchAddr),
    .pc           (pc),
    .linkPc       (linkPc),
    .xSkip        (xSkip),
    .atom         (atom)
  );

endmodule

`default_nettype wire

//--- testbench/branchUnit_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit_assertions (
  input logic                gclk,
  input logic                grst,
  input logic                xEn,
  input branchPkg::decodeRec rec,
  input logic                dSkip,
  input logic                fSkip,
  input logic                xSkip
);
  import branchPkg::*;

  // execute skip flag carries dSkip across an xEn edge
  xSkipTracksDSkip: assert property (@(posedge gclk) disable iff (grst)
    xEn |=> (xSkip == $past(dSkip)))
    else $error("xSkip did not take dSkip on an xEn edge");

  // reset clears the execute skip flag
  resetClearsXSkip: assert property (@(posedge gclk) grst |=> !xSkip)
    else $error("xSkip still high after a reset edge");

  // squash empties the decode record
  squashClearsRec: assert property (@(posedge gclk) disable iff (grst)
    fSkip |=> (rec.cls == OTHER))
    else $error("decode record not cleared after fSkip");

endmodule

// attach to every branchUnit instance
bind branchUnit branchUnit_assertions u_assertions (
  .gclk  (gclk),
  .grst  (grst),
  .xEn   (xEn),
  .rec   (rec),
  .dSkip (dSkip),
  .fSkip (fSkip),
  .xSkip (xSkip)
);

`default_nettype wire

//--- testbench/tbBranchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tbBranchUnit;
  import branchPkg::*;

  logic        gclk;
  logic        grst;
  logic        dEn;
  logic        xEn;
  logic [31:0] instWord;
  fwdSel       mxAlt;
  operandIn    operands;
  logic        fetchAdvance;
  logic [31:0] fetchAddr;
  pcWord       pc;
  pcWord       linkPc;
  logic        dSkip;
  logic        xSkip;
  logic [1:0]  atom;

  // one vector from the case file
  logic [31:0] vInst, vMx, vRegA, vResult, vLoad, vAdv, vDEn, vXEn;
  logic [31:0] eTaken, eDSkip, eFetch, ePc, eLink, eXSkip, eAtom;
  logic [31:0] lfsrState;
  int          caseNum;

  branchUnit u_branchUnit (
    .gclk         (gclk),
    .grst         (grst),
    .dEn          (dEn),
    .xEn          (xEn),
    .instWord     (instWord),
    .mxAlt        (mxAlt),
    .operands     (operands),
    .fetchAdvance (fetchAdvance),
    .fetchAddr    (fetchAddr),
    .pc           (pc),
    .linkPc       (linkPc),
    .dSkip        (dSkip),
    .xSkip        (xSkip),
    .atom         (atom)
  );

  // 40 ns period
  always #20 gclk = ~gclk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic drawWord(output logic [31:0] w);
    int i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[30:0], lfsrState[0]};
    end
  endtask

  // a falling edge comes within two clock cycles
  task automatic waitFall();
    int edges;
    edges = 0;
    do begin
      @(gclk);
      edges++;
    end while (gclk !== 1'b0 && edges < 4);
    if (gclk !== 1'b0) begin
      failRun("timeout waiting for a falling clock edge");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s in case %0d: got 0x%h expected 0x%h", name, caseNum, got, exp);
      failRun("bit check failed");
    end
  endtask

  task automatic checkPc(input string name, input pcWord got, input pcWord exp);
    if (got !== exp) begin
      $display("mismatch %s in case %0d: got 0x%h expected 0x%h", name, caseNum, got, exp);
      failRun("word address check failed");
    end
  endtask

  task automatic checkAddr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s in case %0d: got 0x%h expected 0x%h", name, caseNum, got, exp);
      failRun("byte address check failed");
    end
  endtask

  task automatic checkAtom(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s in case %0d: got 0x%h expected 0x%h", name, caseNum, got, exp);
      failRun("atomic tracker check failed");
    end
  endtask

  // apply a vector and fill the operands that cannot matter from the lfsr
  task automatic driveCase();
    logic [31:0] fill;
    instWord          = vInst;
    mxAlt             = fwdSel'(vMx[1:0]);
    operands.regA     = vRegA;
    operands.result   = vResult;
    operands.loadData = vLoad;
    fetchAdvance      = vAdv[0];
    dEn               = vDEn[0];
    xEn               = vXEn[0];
    if (mxAlt != REGA) begin
      drawWord(fill);
      operands.regA = fill;
    end
    // result doubles as the target and stays when the branch goes
    if (mxAlt != RESULT && eTaken[0] == 1'b0) begin
      drawWord(fill);
      operands.result = fill;
    end
    if (mxAlt != LOADDATA) begin
      drawWord(fill);
      operands.loadData = fill;
    end
  endtask

  task automatic checkCase();
    checkBit("taken", u_branchUnit.taken, eTaken[0]);
    checkBit("dSkip", dSkip, eDSkip[0]);
    checkAddr("fetchAddr", fetchAddr, eFetch);
    checkPc("pc", pc, ePc[29:0]);
    checkPc("linkPc", linkPc, eLink[29:0]);
    checkBit("xSkip", xSkip, eXSkip[0]);
    checkAtom("atom", atom, eAtom[1:0]);
  endtask

  initial begin
    int    fd;
    int    status;
    int    fields;
    int    lineCount;
    string line;
    lfsrState    = 32'hcc98;
    caseNum      = 0;
    gclk         = 1'b0;
    grst         = 1'b1;
    dEn          = 1'b0;
    xEn          = 1'b0;
    instWord     = '0;
    mxAlt        = REGA;
    operands     = '0;
    fetchAdvance = 1'b0;
    fd = $fopen("testbench/branch_cases.txt", "r");
    if (fd == 0) begin
      failRun("could not open testbench/branch_cases.txt");
    end
    // four rising edges in reset
    repeat (4) waitFall();
    grst = 1'b0;
    lineCount = 0;
    while (!$feof(fd) && lineCount < 500) begin
      lineCount++;
      line = "";
      status = $fgets(line, fd);
      // skip blanks and # comment lines
      if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          vInst, vMx, vRegA, vResult, vLoad, vAdv, vDEn, vXEn,
          eTaken, eDSkip, eFetch, ePc, eLink, eXSkip, eAtom);
        if (fields != 15) begin
          failRun("malformed line in the case file");
        end
        caseNum++;
        driveCase();
        // outputs settle well before the rising edge
        #10;
        checkCase();
        waitFall();
      end
    end
    if (!$feof(fd)) begin
      failRun("case file did not end within 500 lines");
    end
    $fclose(fd);
    if (caseNum == 0) begin
      failRun("case file held no vectors");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- build.f
verilog/branchPkg.sv
verilog/instDecode.sv
verilog/branchResolve.sv
verilog/pcPipeline.sv
verilog/branchUnit.sv
testbench/branchUnit_assertions.sv
testbench/tbBranchUnit.sv

//--- Makefile
# Verilator flow for the branch unit testbench

TOP := tbBranchUnit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

# the run fails through the simulator's exit status on $fatal
run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

//--- testbench/branch_cases.txt
# instWord mxAlt regA result loadData fetchAdvance dEn xEn, all hex
# expected: taken dSkip fetchAddr pc linkPc xSkip atom (pc and linkPc are word addresses)
00430800 0 00000000 00000000 00000000 1 1 0 0 0 00000004 0 0 0 0
00430800 0 00000000 00000000 00000000 0 1 0 0 0 00000000 0 0 0 0
00430800 0 00000000 00000000 00000000 1 1 1 0 0 00000004 0 0 0 0
00430800 0 00000000 00000000 00000000 1 1 1 0 0 00000008 0 0 0 1
00430800 0 00000000 00000000 00000000 1 1 1 0 0 0000000c 0 0 0 2
00430800 0 00000000 00000000 00000000 1 1 0 0 0 00000010 1 0 0 1
00430800 0 00000000 00000000 00000000 0 1 0 0 0 0000000c 1 0 0 1
00430800 0 00000000 00000000 00000000 1 1 1 0 0 00000010 1 0 0 1
98000000 0 00000000 00000000 00000000 1 1 0 0 0 00000014 2 1 0 2
00430800 0 00000000 00001230 00000000 1 0 1 1 1 00001230 2 1 0 2
00430800 0 00000000 00000000 00000000 0 0 0 0 0 00001230 3 2 1 0
98100000 0 00000000 00000000 00000000 0 1 0 0 0 00001230 3 2 1 0
00430800 0 00000000 00002000 00000000 1 0 1 1 0 00002000 3 2 1 0
00430800 0 00000000 00002004 00000000 0 0 0 1 0 00002004 4 3 0 0
00430800 0 00000000 00002004 00000000 0 1 0 1 0 00002004 4 3 0 0
9e000000 0 00000000 00000000 00000000 0 1 0 0 0 00002000 4 3 0 0
00430800 0 00000000 00003000 00000000 0 0 0 1 0 00003000 4 3 0 0
00430800 0 00000104 00000000 00000000 0 0 0 0 0 00002000 4 3 0 0
be200000 0 ffffff00 00000000 00000000 0 1 0 0 0 00002000 4 3 0 0
00430800 1 00000000 00000000 00000000 0 0 0 0 0 00002000 4 3 0 0
00430800 1 00000000 00000104 00000000 0 0 0 1 0 00000104 4 3 0 0
9e400000 1 00000000 ffffff00 00000000 0 1 0 1 0 ffffff00 4 3 0 0
00430800 2 00000000 00000000 00000000 0 0 0 0 0 00002000 4 3 0 0
00430800 2 00000000 00000000 00000104 0 0 0 0 0 00002000 4 3 0 0
be600000 2 00000000 00003000 ffffff00 0 1 0 1 0 00003000 4 3 0 0
00430800 0 00000000 00003000 00000000 0 0 0 1 0 00003000 4 3 0 0
00430800 0 00000104 00000000 00000000 0 0 0 0 0 00002000 4 3 0 0
9e800000 0 ffffff00 00003000 00000000 0 1 0 1 0 00003000 4 3 0 0
00430800 1 00000000 00000000 00000000 0 0 0 0 0 00002000 4 3 0 0
00430800 1 00000000 00000104 00000000 0 0 0 1 0 00000104 4 3 0 0
bea00000 1 00000000 ffffff00 00000000 0 1 0 0 0 00002000 4 3 0 0
00430800 2 00000000 00003000 00000000 0 0 0 1 0 00003000 4 3 0 0
00430800 2 00000000 00003000 00000104 0 0 0 1 0 00003000 4 3 0 0
9c200000 2 00000000 00000000 ffffff00 0 1 0 0 0 00002000 4 3 0 0
b0000000 0 00000104 00004000 00000000 0 1 1 1 1 00004000 4 3 0 0
b0000000 0 00000000 00000000 00000000 1 1 1 0 0 00004004 48c 4 1 0
b4000000 0 00000000 00000000 00000000 1 1 1 0 0 00004008 800 48c 0 1
00430800 0 00000000 00000000 00000000 1 1 1 0 0 0000400c 1000 800 0 3
00430800 0 00000000 00000000 00000000 1 1 1 0 0 00004010 1001 1000 0 3
00430800 0 00000000 00000000 00000000 0 0 0 0 0 00004010 1002 1001 0 2
00430800 0 00000000 00000000 00000000 0 0 1 0 0 00004010 1002 1001 0 2
00430800 0 00000000 00000000 00000000 0 0 0 0 0 00004010 1003 1002 0 1
